//--- common/fetch_pkg.sv
package fetch_pkg;

    // datapath and address width
    localparam int xlen = 32;

    // boot ROM entry, also the debug reset target
    localparam logic [xlen-1:0] reset_vector = 32'hbfc00000;

    // fetch queue entries
    localparam int fetch_depth = 4;

    // memory requests allowed in flight
    localparam int inflight_depth = 2;

    // occupancy counters hold 0 through depth inclusive
    localparam int fetch_cnt_w = $clog2(fetch_depth + 1);
    localparam int inflight_cnt_w = $clog2(inflight_depth + 1);

    // one fetched instruction on its way to decode
    typedef struct packed {
        logic [xlen-1:0] pc;
        logic [xlen-1:0] instr;
    } fetch_entry_t;

    // tag kept per outstanding memory request
    typedef struct packed {
        logic [xlen-1:0] pc;
        logic            epoch;
    } inflight_t;

endpackage

//--- common/imem_if.sv
`timescale 1ns/10ps

interface imem_if import fetch_pkg::*; ();

    // request channel, word address
    logic            req_valid;
    logic            req_ready;
    logic [xlen-1:0] req_addr;

    // response channel, in order and never stalled
    logic            rsp_valid;
    logic [xlen-1:0] rsp_data;

    // fetch unit side
    modport master (
        output req_valid,
        output req_addr,
        input  req_ready,
        input  rsp_valid,
        input  rsp_data
    );

    // memory side
    modport slave (
        input  req_valid,
        input  req_addr,
        output req_ready,
        output rsp_valid,
        output rsp_data
    );

endinterface

//--- src/sync_fifo.sv
`timescale 1ns/10ps

module sync_fifo #(
    parameter type payload_t = logic [31:0],
    parameter int  depth     = 4
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       flush,
    input  logic                       push,
    input  payload_t                   push_data,
    input  logic                       pop,
    output payload_t                   pop_data,
    output logic                       empty,
    output logic                       full,
    output logic [$clog2(depth+1)-1:0] count
);

    // entry storage
    payload_t mem [depth];

    logic [$clog2(depth)-1:0] wr_ptr;
    logic [$clog2(depth)-1:0] rd_ptr;

    // head is read straight out of the array
    assign pop_data = mem[rd_ptr];

    assign empty = (count == '0);
    assign full  = (count == depth);

    // pointers wrap at depth
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                if (wr_ptr == depth - 1) begin
                    wr_ptr <= '0;
                end else begin
                    wr_ptr <= wr_ptr + 1'b1;
                end
            end
            if (pop) begin
                if (rd_ptr == depth - 1) begin
                    rd_ptr <= '0;
                end else begin
                    rd_ptr <= rd_ptr + 1'b1;
                end
            end
            // push and pop together leave count alone
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // write port
    always_ff @(posedge clk) begin
        if (push && !flush) begin
            mem[wr_ptr] <= push_data;
        end
    end

endmodule

//--- src/branch_target.sv
`timescale 1ns/10ps

module branch_target import fetch_pkg::*; (
    input  logic            clk,
    input  logic            rst,
    input  logic            dbg_reset,
    input  logic            dbg_valid,
    input  logic [xlen-1:0] dbg_pc,
    input  logic            exc_valid,
    input  logic [xlen-1:0] exc_pc,
    input  logic            br_taken,
    input  logic [xlen-1:0] br_pc,
    input  logic [xlen-1:0] br_imm,
    output logic            redirect_valid,
    output logic [xlen-1:0] redirect_pc
);

    logic [xlen-1:0] br_dest;
    logic            sel_valid;
    logic [xlen-1:0] sel_pc;

    // word offset, top two immediate bits fall off
    assign br_dest = br_pc + {br_imm[xlen-3:0], 2'b00};

    // debug reset beats debug target beats exception beats branch
    always_comb begin
        sel_valid = 1'b1;
        if (dbg_reset) begin
            sel_pc = reset_vector;
        end else if (dbg_valid) begin
            sel_pc = dbg_pc;
        end else if (exc_valid) begin
            sel_pc = exc_pc;
        end else if (br_taken) begin
            sel_pc = br_dest;
        end else begin
            // nothing pending
            sel_valid = 1'b0;
            sel_pc    = br_dest;
        end
    end

    // single cycle pulse toward pc_gen
    always_ff @(posedge clk) begin
        if (rst) begin
            redirect_valid <= 1'b0;
        end else begin
            redirect_valid <= sel_valid;
        end
    end

    // target only matters alongside the pulse
    always_ff @(posedge clk) begin
        if (sel_valid) begin
            redirect_pc <= sel_pc;
        end
    end

endmodule

//--- pc_gen/pc_gen.sv
`timescale 1ns/10ps

module pc_gen import fetch_pkg::*; (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   redirect_valid,
    input  logic [xlen-1:0]        redirect_pc,
    input  logic [fetch_cnt_w-1:0] queue_count,
    input  logic                   queue_pop,
    imem_if.master                 imem,
    output logic                   push_valid,
    output fetch_entry_t           push_entry,
    output logic                   flush
);

    logic [xlen-1:0]           pc;
    logic                      epoch;
    logic                      run;
    logic                      req_fire;
    logic                      credit_ok;
    logic [fetch_cnt_w:0]      credit_used;
    inflight_t                 tag_in;
    inflight_t                 tag_out;
    logic                      tag_full;
    logic [inflight_cnt_w-1:0] inflight_cnt;
    logic [inflight_cnt_w-1:0] stale_cnt;
    logic [inflight_cnt_w-1:0] stale_next;
    logic                      rsp_keep;

    // issue held off until the first edge out of reset
    always_ff @(posedge clk) begin
        if (rst) begin
            run <= 1'b0;
        end else begin
            run <= 1'b1;
        end
    end

    // slots taken = requests in flight plus entries waiting for decode
    assign credit_used = queue_count + inflight_cnt;

    // a pop at this edge frees its slot right away
    // sum only drops until the next issue so req_valid stays up once raised
    assign credit_ok = (credit_used < fetch_depth + queue_pop) && !tag_full;

    assign imem.req_valid = run && credit_ok;
    // redirect moves the address even if the old request was never taken
    assign imem.req_addr  = pc;
    assign req_fire       = imem.req_valid && imem.req_ready;

    // pc and epoch
    always_ff @(posedge clk) begin
        if (rst) begin
            pc    <= reset_vector;
            epoch <= 1'b0;
        end else if (redirect_valid) begin
            pc    <= redirect_pc;
            epoch <= ~epoch;
        end else if (req_fire) begin
            pc <= pc + xlen'(4);
        end
    end

    // tag every accepted request with its pc and the epoch it left under
    assign tag_in.pc    = pc;
    assign tag_in.epoch = epoch;

    // responses come back in order so the head tag always matches
    sync_fifo #(
        .payload_t (inflight_t),
        .depth     (inflight_depth)
    ) tag_q (
        .clk       (clk),
        .rst       (rst),
        .flush     (1'b0),
        .push      (req_fire),
        .push_data (tag_in),
        .pop       (imem.rsp_valid),
        .pop_data  (tag_out),
        .empty     (),
        .full      (tag_full),
        .count     (inflight_cnt)
    );

    // one epoch bit aliases after two redirects in quick succession
    // so also count what was already out when the last redirect hit
    always_comb begin
        stale_next = stale_cnt;
        if (redirect_valid) begin
            // everything still out after this edge is dead
            stale_next = inflight_cnt + req_fire - imem.rsp_valid;
        end else if (imem.rsp_valid && stale_cnt != '0) begin
            stale_next = stale_cnt - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            stale_cnt <= '0;
        end else begin
            stale_cnt <= stale_next;
        end
    end

    // current path only; the queue is being flushed on a redirect edge
    assign rsp_keep = imem.rsp_valid && (tag_out.epoch == epoch) && (stale_cnt == '0)
                      && !redirect_valid;

    assign push_valid       = rsp_keep;
    assign push_entry.pc    = tag_out.pc;
    assign push_entry.instr = imem.rsp_data;

    // queue drops its contents on the same edge the pc reloads
    assign flush = redirect_valid;

endmodule

//--- src/fetch_top.sv
`timescale 1ns/10ps

module fetch_top import fetch_pkg::*; (
    input  logic            clk,
    input  logic            rst,
    input  logic            dbg_reset,
    input  logic            dbg_valid,
    input  logic [xlen-1:0] dbg_pc,
    input  logic            exc_valid,
    input  logic [xlen-1:0] exc_pc,
    input  logic            br_taken,
    input  logic [xlen-1:0] br_pc,
    input  logic [xlen-1:0] br_imm,
    input  logic            req_ready,
    input  logic            rsp_valid,
    input  logic [xlen-1:0] rsp_data,
    input  logic            out_ready,
    output logic            req_valid,
    output logic [xlen-1:0] req_addr,
    output logic            out_valid,
    output logic [xlen-1:0] out_pc,
    output logic [xlen-1:0] out_instr
);

    logic                   redirect_valid;
    logic [xlen-1:0]        redirect_pc;
    logic                   push_valid;
    fetch_entry_t           push_entry;
    logic                   flush;
    fetch_entry_t           head;
    logic                   q_empty;
    logic [fetch_cnt_w-1:0] queue_count;
    logic                   queue_pop;

    imem_if imem_bus ();

    // memory pins onto the bus
    assign imem_bus.req_ready = req_ready;
    assign imem_bus.rsp_valid = rsp_valid;
    assign imem_bus.rsp_data  = rsp_data;
    assign req_valid          = imem_bus.req_valid;
    assign req_addr           = imem_bus.req_addr;

    // redirect sources resolved and registered
    branch_target redir (
        .clk            (clk),
        .rst            (rst),
        .dbg_reset      (dbg_reset),
        .dbg_valid      (dbg_valid),
        .dbg_pc         (dbg_pc),
        .exc_valid      (exc_valid),
        .exc_pc         (exc_pc),
        .br_taken       (br_taken),
        .br_pc          (br_pc),
        .br_imm         (br_imm),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc)
    );

    pc_gen pcg (
        .clk            (clk),
        .rst            (rst),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .queue_count    (queue_count),
        .queue_pop      (queue_pop),
        .imem           (imem_bus.master),
        .push_valid     (push_valid),
        .push_entry     (push_entry),
        .flush          (flush)
    );

    // decode handshake
    assign out_valid = !q_empty;
    assign queue_pop = out_valid && out_ready;

    // fetch queue, never overfilled thanks to credits in pc_gen
    sync_fifo #(
        .payload_t (fetch_entry_t),
        .depth     (fetch_depth)
    ) fetch_q (
        .clk       (clk),
        .rst       (rst),
        .flush     (flush),
        .push      (push_valid),
        .push_data (push_entry),
        .pop       (queue_pop),
        .pop_data  (head),
        .empty     (q_empty),
        .full      (),
        .count     (queue_count)
    );

    assign out_pc    = head.pc;
    assign out_instr = head.instr;

endmodule

//--- tests/fetch_props.sv
`timescale 1ns/10ps

module fetch_props import fetch_pkg::*; (
    input logic                   clk,
    input logic                   rst,
    input logic                   req_valid,
    input logic                   req_ready,
    input logic [xlen-1:0]        req_addr,
    input logic                   out_valid,
    input logic                   out_ready,
    input logic [xlen-1:0]        out_pc,
    input logic [xlen-1:0]        out_instr,
    input logic                   flush,
    input logic                   push_valid,
    input logic [fetch_cnt_w-1:0] queue_count
);

    // bumped on every failed property
    int fail_cnt = 0;

    // stalled decode keeps its entry unless a redirect flushes the queue
    out_hold: assert property (@(posedge clk) disable iff (rst)
        out_valid && !out_ready && !flush
        |=> out_valid && $stable(out_pc) && $stable(out_instr))
    else begin
        $error("decode entry changed while decode was stalled");
        fail_cnt++;
    end

    // stalled memory request keeps its address until a redirect
    req_hold: assert property (@(posedge clk) disable iff (rst)
        req_valid && !req_ready && !flush |=> req_valid && $stable(req_addr))
    else begin
        $error("memory request dropped or moved while memory was stalled");
        fail_cnt++;
    end

    // credits keep the fetch queue from overfilling
    push_room: assert property (@(posedge clk) disable iff (rst)
        push_valid |-> queue_count < fetch_depth)
    else begin
        $error("fetch queue pushed while full");
        fail_cnt++;
    end

endmodule

//--- tests/fetch_tb.sv
`timescale 1ns/10ps

module fetch_tb import fetch_pkg::*; ();

    localparam int n_segments = 60;
    // every fifth segment ends in a back to back pair
    localparam int n_redirects = n_segments + n_segments / 5;
    localparam int watchdog_cycles = 10 + 2000 + 50 * n_redirects;
    localparam logic [xlen-1:0] instr_key = 32'h5a5a5a5a;

    logic            clk;
    logic            rst;
    logic            dbg_reset, dbg_valid, exc_valid, br_taken;
    logic [xlen-1:0] dbg_pc, exc_pc, br_pc, br_imm;
    logic            req_ready, rsp_valid, out_ready;
    logic [xlen-1:0] rsp_data;
    logic            req_valid, out_valid;
    logic [xlen-1:0] req_addr, out_pc, out_instr;

    // memory model holds accepted addresses and the cycle each answer is due
    logic [xlen-1:0] mem_addr[$];
    int unsigned     mem_due[$];
    int unsigned     cyc;
    int unsigned     lat;
    int unsigned     rdy_pct, out_pct;

    // scoreboard
    logic [xlen-1:0] exp_pc;
    logic            pend_valid;
    logic [xlen-1:0] pend_pc;
    int              held, stale_left, since_redir;
    bit              seen_edge;

    fetch_top dut0 (.*);

    bind fetch_top fetch_props props0 (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Verification failed");
        $fatal(1);
    endtask

    // debug reset, debug target, exception, then branch
    function automatic logic [xlen-1:0] resolve_target();
        return dbg_reset ? reset_vector :
               dbg_valid ? dbg_pc :
               exc_valid ? exc_pc :
               br_pc + (br_imm << 2);
    endfunction

    // usually one kind and now and then several at once
    function automatic logic [3:0] pick_sources();
        logic [3:0] srcs;
        srcs = 4'b0001 << ($urandom % 4);
        if ($urandom % 4 == 0) begin
            srcs = srcs | 4'($urandom % 16);
        end
        return srcs;
    endfunction

    // all inputs change on the falling edge
    task automatic drive_cycle(input logic [3:0] srcs);
        @(negedge clk);
        req_ready = ($urandom % 100) < rdy_pct;
        out_ready = ($urandom % 100) < out_pct;
        lat       = 1 + $urandom % 3;
        // responses in order as the head falls due
        rsp_valid = 1'b0;
        rsp_data  = $urandom;
        if (mem_due.size() != 0 && mem_due[0] <= cyc + 1) begin
            rsp_valid = 1'b1;
            rsp_data  = mem_addr[0] ^ instr_key;
        end
        {br_taken, exc_valid, dbg_valid, dbg_reset} = srcs;
        dbg_pc = $urandom & ~32'h3;
        exc_pc = $urandom & ~32'h3;
        br_pc  = $urandom & ~32'h3;
        // mostly small signed offsets and now and then one whose top bits fall off
        br_imm = ($urandom % 4 == 0) ? $urandom : $urandom % 2048 - 1024;
    endtask

    initial begin
        repeat (watchdog_cycles) @(posedge clk);
        abort_run("timeout: fetch stopped delivering before the run ended");
    end

    always @(posedge clk) begin
        if (rst) begin
            // nothing leaves the front end while reset is held
            if (seen_edge) begin
                assert (req_valid === 1'b0 && out_valid === 1'b0)
                    else abort_run("req_valid or out_valid raised during reset");
            end
            seen_edge   = 1'b1;
            exp_pc      = reset_vector;
            pend_valid  = 1'b0;
            held        = 0;
            stale_left  = 0;
            since_redir = 0;
            cyc         = 0;
            mem_addr.delete();
            mem_due.delete();
        end else begin
            cyc++;
            assert (dut0.props0.fail_cnt == 0)
                else abort_run("a handshake property in fetch_props failed");
            assert (out_valid === (held > 0))
                else abort_run($sformatf("mismatch out_valid got 0x%0h expected 0x%0h",
                                         out_valid, held > 0));
            // decode transfers arrive in path order
            if (out_valid && out_ready) begin
                assert (out_pc === exp_pc)
                    else abort_run($sformatf("mismatch out_pc got 0x%08h expected 0x%08h",
                                             out_pc, exp_pc));
                assert (out_instr === (exp_pc ^ instr_key))
                    else abort_run($sformatf("mismatch out_instr got 0x%08h expected 0x%08h",
                                             out_instr, exp_pc ^ instr_key));
                exp_pc = exp_pc + 32'd4;
                held--;
                since_redir++;
            end
            // answers on a redirect edge or from a dead path never reach decode
            if (rsp_valid) begin
                void'(mem_addr.pop_front());
                void'(mem_due.pop_front());
                if (!pend_valid) begin
                    if (stale_left > 0) begin
                        stale_left--;
                    end else begin
                        held++;
                    end
                end
            end
            if (req_valid && req_ready) begin
                mem_addr.push_back(req_addr);
                mem_due.push_back(cyc + lat);
            end
            // redirect lands one edge after its sources were seen
            if (pend_valid) begin
                exp_pc      = pend_pc;
                held        = 0;
                stale_left  = mem_addr.size();
                since_redir = 0;
            end
            pend_valid = dbg_reset | dbg_valid | exc_valid | br_taken;
            pend_pc    = resolve_target();
            assert (mem_addr.size() + held <= fetch_depth)
                else abort_run($sformatf("outstanding %0d plus queued %0d exceed the queue depth",
                                         mem_addr.size(), held));
        end
    end

    initial begin
        void'($urandom(86905));
        rst = 1'b1;
        {br_taken, exc_valid, dbg_valid, dbg_reset} = 4'b0000;
        dbg_pc    = '0;
        exc_pc    = '0;
        br_pc     = '0;
        br_imm    = '0;
        req_ready = 1'b0;
        rsp_valid = 1'b0;
        rsp_data  = '0;
        out_ready = 1'b0;
        lat       = 1;
        rdy_pct   = 50;
        out_pct   = 50;
        repeat (10) @(negedge clk);
        rst = 1'b0;
        for (int s = 0; s < n_segments; s++) begin
            // stall level of memory and decode per segment
            rdy_pct = 20 + $urandom % 81;
            out_pct = 10 + $urandom % 91;
            repeat (5 + $urandom % 26) drive_cycle(4'b0000);
            drive_cycle(pick_sources());
            if (s % 5 == 4) begin
                drive_cycle(pick_sources());
            end
        end
        // let the last redirect land and its path deliver a few
        rdy_pct = 70;
        out_pct = 70;
        repeat (3) drive_cycle(4'b0000);
        while (since_redir < 8) begin
            drive_cycle(4'b0000);
        end
        if (dut0.props0.fail_cnt == 0) begin
            $display("Verification passed");
            $finish;
        end else begin
            $display("Verification failed");
            $fatal(1);
        end
    end

endmodule

//--- mips_fetch.f
common/fetch_pkg.sv
common/imem_if.sv
src/sync_fifo.sv
src/branch_target.sv
pc_gen/pc_gen.sv
src/fetch_top.sv
tests/fetch_props.sv
tests/fetch_tb.sv

//--- Bender.yml
package:
  name: mips_fetch

sources:
  - common/fetch_pkg.sv
  - common/imem_if.sv
  - src/sync_fifo.sv
  - src/branch_target.sv
  - pc_gen/pc_gen.sv
  - src/fetch_top.sv
  - target: test
    files:
      - tests/fetch_props.sv
      - tests/fetch_tb.sv
